//--- l2_mem_pkg.sv
//****************************************
// L2 local memory types
//****************************************
package l2_mem_pkg;

    // cache slice geometry
    localparam int L2_WAYS      = 4;
    localparam int L2_SET_BITS  = 6;
    localparam int L2_TAG_BITS  = 12;
    localparam int L2_LINE_BITS = 64;

    localparam int L2_WAY_BITS  = (L2_WAYS > 1) ? $clog2(L2_WAYS) : 1;

    // set index
    typedef logic [L2_SET_BITS-1:0] l2_set_t;

    // way index, also the eviction pointer
    typedef logic [L2_WAY_BITS-1:0] l2_way_t;

    typedef logic [L2_TAG_BITS-1:0] l2_tag_t;

    typedef logic [L2_LINE_BITS-1:0] line_t;

    typedef logic [0:0] hprot_t;

    // one bit per way of a set
    typedef logic [L2_WAYS-1:0] l2_way_mask_t;

    // coherence state of one way
    typedef enum logic [2:0] {
        INVALID     = 3'd0,
        SHARED      = 3'd1,
        EXCLUSIVE   = 3'd2,
        MODIFIED    = 3'd3,
        SD          = 3'd4,
        STATE_RSVD5 = 3'd5,
        STATE_RSVD6 = 3'd6,
        STATE_RSVD7 = 3'd7
    } state_t;

    // which per-way field a bank array stores
    typedef enum logic [1:0] {
        FIELD_LINE  = 2'd0,
        FIELD_TAG   = 2'd1,
        FIELD_HPROT = 2'd2,
        FIELD_STATE = 2'd3
    } l2_field_t;

endpackage

//--- l2_wr_if.sv
//****************************************
// L2 decoded write request
//****************************************
`timescale 1ns/1ps

interface l2_wr_if;
    import l2_mem_pkg::*;

    // target set and selected ways
    l2_set_t      set;
    l2_way_mask_t way_mask;

    // per-field write enables
    logic         we_line;
    logic         we_tag;
    logic         we_hprot;
    logic         we_state;
    logic         we_evict;

    // write data
    line_t        line;
    l2_tag_t      tag;
    hprot_t       hprot;
    state_t       state;
    l2_way_t      evict_way;

    modport dec (
        output set, way_mask,
        output we_line, we_tag, we_hprot, we_state, we_evict,
        output line, tag, hprot, state, evict_way
    );

    modport mem (
        input set, way_mask,
        input we_line, we_tag, we_hprot, we_state, we_evict,
        input line, tag, hprot, state, evict_way
    );

endinterface

//--- l2_way_decoder.sv
//****************************************
// L2 write enable decoder
//****************************************
`timescale 1ns/1ps

module l2_way_decoder (
    input  logic                 wr_en_line,
    input  logic                 wr_en_state,
    input  logic                 wr_en_evict_way,
    input  logic                 wr_en_put_reqs,
    input  logic                 wr_all_ways,
    input  l2_mem_pkg::l2_set_t  set_in,
    input  l2_mem_pkg::l2_way_t  way,
    input  l2_mem_pkg::line_t    wr_data_line,
    input  l2_mem_pkg::l2_tag_t  wr_data_tag,
    input  l2_mem_pkg::hprot_t   wr_data_hprot,
    input  l2_mem_pkg::state_t   wr_data_state,
    input  l2_mem_pkg::l2_way_t  wr_data_evict_way,
    l2_wr_if.dec                 wr
);
    import l2_mem_pkg::*;

    l2_way_mask_t way_mask;

    // one-hot way, or every way for the state init
    always_comb begin
        way_mask = '0;
        if (wr_all_ways) begin
            way_mask = '1;
        end else begin
            way_mask[way] = 1'b1;
        end
    end

    assign wr.set      = set_in;
    assign wr.way_mask = way_mask;

    // a put request writes every field of the way
    assign wr.we_line  = wr_en_line | wr_en_put_reqs;
    assign wr.we_tag   = wr_en_put_reqs;
    assign wr.we_hprot = wr_en_put_reqs;
    assign wr.we_state = wr_en_state | wr_en_put_reqs | wr_all_ways;

    // eviction pointer is per set, so way selection does not apply
    assign wr.we_evict = wr_en_evict_way;

    assign wr.line      = wr_data_line;
    assign wr.tag       = wr_data_tag;
    assign wr.hprot     = wr_data_hprot;
    assign wr.state     = wr_data_state;
    assign wr.evict_way = wr_data_evict_way;

    // the all-ways mask would spread line and tag data over the whole set
    always_comb begin
        assert final (!(wr_all_ways && (wr_en_line || wr_en_put_reqs)))
        else $error("wr_all_ways together with a line or put-request write");
    end

endmodule

//--- l2_bank_array.sv
//****************************************
// L2 banked per-way field memory
//****************************************
`timescale 1ns/1ps

module l2_bank_array #(
    parameter int                    DATA_BITS = 8,
    parameter int                    BANKS     = 1,
    parameter l2_mem_pkg::l2_field_t field_sel = l2_mem_pkg::FIELD_LINE
) (
    input  logic                 clk,
    input  logic                 wr_rst,
    input  logic                 rd_en,
    l2_wr_if.mem                 wr,
    output logic [DATA_BITS-1:0] rd_data [l2_mem_pkg::L2_WAYS]
);
    import l2_mem_pkg::*;

    localparam int IDX_BITS = $clog2(BANKS);
    localparam int IDX_W    = (IDX_BITS > 0) ? IDX_BITS : 1;
    localparam int ROW_BITS = L2_SET_BITS - IDX_BITS;
    localparam int PAIRS    = L2_WAYS / 2;
    localparam int DEPTH    = 2 ** (ROW_BITS + 1);

    logic [DATA_BITS-1:0] wr_data;
    logic                 field_we;
    logic [IDX_W-1:0]     bank;
    logic [IDX_W-1:0]     rd_bank_q;
    logic [ROW_BITS-1:0]  row;
    logic [DATA_BITS-1:0] bank_q [BANKS][L2_WAYS];

    if (L2_WAYS % 2 != 0) begin : g_odd_ways
        $error("ways are paired on two ports, L2_WAYS must be even");
    end

    always_comb begin
        case (field_sel)
            FIELD_TAG: begin
                wr_data  = DATA_BITS'(wr.tag);
                field_we = wr.we_tag;
            end
            FIELD_HPROT: begin
                wr_data  = DATA_BITS'(wr.hprot);
                field_we = wr.we_hprot;
            end
            FIELD_STATE: begin
                wr_data  = DATA_BITS'(wr.state);
                field_we = wr.we_state;
            end
            default: begin
                wr_data  = DATA_BITS'(wr.line);
                field_we = wr.we_line;
            end
        endcase
    end

    // upper set bits pick the bank, the rest address a row
    if (IDX_BITS > 0) begin : g_idx
        assign bank = wr.set[L2_SET_BITS-1 -: IDX_BITS];
    end else begin : g_no_idx
        assign bank = '0;
    end
    assign row = wr.set[ROW_BITS-1:0];

    for (genvar b = 0; b < BANKS; b++) begin : g_bank
        for (genvar p = 0; p < PAIRS; p++) begin : g_pair
            logic [DATA_BITS-1:0] mem [DEPTH];
            logic [DATA_BITS-1:0] q_a;
            logic [DATA_BITS-1:0] q_b;
            logic                 we_a;
            logic                 we_b;

            assign we_a = field_we && (int'(bank) == b) && wr.way_mask[2*p];
            assign we_b = field_we && (int'(bank) == b) && wr.way_mask[2*p+1];

            // even way in the lower half, odd way in the upper half
            always_ff @(posedge clk) begin
                if (we_a) begin
                    mem[{1'b0, row}] <= wr_data;
                end
                if (we_b) begin
                    mem[{1'b1, row}] <= wr_data;
                end
            end

            always_ff @(posedge clk) begin
                if (wr_rst) begin
                    q_a <= '0;
                    q_b <= '0;
                end else if (rd_en) begin
                    q_a <= mem[{1'b0, row}];
                    q_b <= mem[{1'b1, row}];
                end
            end

            assign bank_q[b][2*p]   = q_a;
            assign bank_q[b][2*p+1] = q_b;
        end
    end

    // bank of the last read, so the mux follows the read address
    always_ff @(posedge clk) begin
        if (wr_rst) begin
            rd_bank_q <= '0;
        end else if (rd_en) begin
            rd_bank_q <= bank;
        end
    end

    always_comb begin
        for (int w = 0; w < L2_WAYS; w++) begin
            rd_data[w] = bank_q[rd_bank_q][w];
        end
    end

    // an access must name a bank that exists
    assert property (@(posedge clk) disable iff (wr_rst)
        (rd_en || field_we) |-> (int'(bank) < BANKS))
    else $error("bank index out of range");

endmodule

//--- l2_evict_mem.sv
//****************************************
// L2 eviction pointer memory
//****************************************
`timescale 1ns/1ps

module l2_evict_mem #(
    parameter int EVICT_BANKS = 1
) (
    input  logic                clk,
    input  logic                wr_rst,
    input  logic                rd_en,
    l2_wr_if.mem                wr,
    output l2_mem_pkg::l2_way_t rd_evict_way
);
    import l2_mem_pkg::*;

    localparam int IDX_BITS = $clog2(EVICT_BANKS);
    localparam int IDX_W    = (IDX_BITS > 0) ? IDX_BITS : 1;
    localparam int ROW_BITS = L2_SET_BITS - IDX_BITS;

    logic [IDX_W-1:0]    bank;
    logic [IDX_W-1:0]    rd_bank_q;
    logic [ROW_BITS-1:0] row;
    l2_way_t             bank_q [EVICT_BANKS];

    if (IDX_BITS > 0) begin : g_idx
        assign bank = wr.set[L2_SET_BITS-1 -: IDX_BITS];
    end else begin : g_no_idx
        assign bank = '0;
    end
    assign row = wr.set[ROW_BITS-1:0];

    for (genvar b = 0; b < EVICT_BANKS; b++) begin : g_bank
        l2_way_t mem [2**ROW_BITS];
        l2_way_t q;

        always_ff @(posedge clk) begin
            if (wr.we_evict && (int'(bank) == b)) begin
                mem[row] <= wr.evict_way;
            end
        end

        always_ff @(posedge clk) begin
            if (wr_rst) begin
                q <= '0;
            end else if (rd_en) begin
                q <= mem[row];
            end
        end

        assign bank_q[b] = q;
    end

    always_ff @(posedge clk) begin
        if (wr_rst) begin
            rd_bank_q <= '0;
        end else if (rd_en) begin
            rd_bank_q <= bank;
        end
    end

    assign rd_evict_way = bank_q[rd_bank_q];

    // a pointer write needs a known set and pointer
    assert property (@(posedge clk) disable iff (wr_rst)
        wr.we_evict |-> !$isunknown({wr.set, wr.evict_way}))
    else $error("eviction pointer write with an unknown set or pointer");

endmodule

//--- l2_localmem.sv
//****************************************
// L2 slice local memory
//****************************************
`timescale 1ns/1ps

module l2_localmem #(
    parameter int LINE_BANKS  = 2,
    parameter int TAG_BANKS   = 2,
    parameter int HPROT_BANKS = 1,
    parameter int STATE_BANKS = 1,
    parameter int EVICT_BANKS = 2
) (
    input  logic                clk,
    input  logic                wr_rst,
    input  logic                rd_en,
    input  logic                wr_en_line,
    input  logic                wr_en_state,
    input  logic                wr_en_evict_way,
    input  logic                wr_en_put_reqs,
    input  logic                wr_all_ways,
    input  l2_mem_pkg::l2_set_t set_in,
    input  l2_mem_pkg::l2_way_t way,
    input  l2_mem_pkg::line_t   wr_data_line,
    input  l2_mem_pkg::l2_tag_t wr_data_tag,
    input  l2_mem_pkg::hprot_t  wr_data_hprot,
    input  l2_mem_pkg::state_t  wr_data_state,
    input  l2_mem_pkg::l2_way_t wr_data_evict_way,

    output l2_mem_pkg::line_t   rd_data_line  [l2_mem_pkg::L2_WAYS],
    output l2_mem_pkg::l2_tag_t rd_data_tag   [l2_mem_pkg::L2_WAYS],
    output l2_mem_pkg::hprot_t  rd_data_hprot [l2_mem_pkg::L2_WAYS],
    output l2_mem_pkg::state_t  rd_data_state [l2_mem_pkg::L2_WAYS],
    output l2_mem_pkg::l2_way_t rd_data_evict_way
);
    import l2_mem_pkg::*;

    // raw state bits, typed back to the enum at the port
    logic [$bits(state_t)-1:0] rd_state_raw [L2_WAYS];

    l2_wr_if wr_bus ();

    l2_way_decoder u_decoder (
        .wr_en_line        (wr_en_line),
        .wr_en_state       (wr_en_state),
        .wr_en_evict_way   (wr_en_evict_way),
        .wr_en_put_reqs    (wr_en_put_reqs),
        .wr_all_ways       (wr_all_ways),
        .set_in            (set_in),
        .way               (way),
        .wr_data_line      (wr_data_line),
        .wr_data_tag       (wr_data_tag),
        .wr_data_hprot     (wr_data_hprot),
        .wr_data_state     (wr_data_state),
        .wr_data_evict_way (wr_data_evict_way),
        .wr                (wr_bus)
    );

    l2_bank_array #(.DATA_BITS(L2_LINE_BITS), .BANKS(LINE_BANKS), .field_sel(FIELD_LINE))
    u_line_mem (
        .clk     (clk),
        .wr_rst  (wr_rst),
        .rd_en   (rd_en),
        .wr      (wr_bus),
        .rd_data (rd_data_line)
    );

    l2_bank_array #(.DATA_BITS(L2_TAG_BITS), .BANKS(TAG_BANKS), .field_sel(FIELD_TAG))
    u_tag_mem (
        .clk     (clk),
        .wr_rst  (wr_rst),
        .rd_en   (rd_en),
        .wr      (wr_bus),
        .rd_data (rd_data_tag)
    );

    l2_bank_array #(.DATA_BITS($bits(hprot_t)), .BANKS(HPROT_BANKS), .field_sel(FIELD_HPROT))
    u_hprot_mem (
        .clk     (clk),
        .wr_rst  (wr_rst),
        .rd_en   (rd_en),
        .wr      (wr_bus),
        .rd_data (rd_data_hprot)
    );

    l2_bank_array #(.DATA_BITS($bits(state_t)), .BANKS(STATE_BANKS), .field_sel(FIELD_STATE))
    u_state_mem (
        .clk     (clk),
        .wr_rst  (wr_rst),
        .rd_en   (rd_en),
        .wr      (wr_bus),
        .rd_data (rd_state_raw)
    );

    for (genvar w = 0; w < L2_WAYS; w++) begin : g_state_out
        assign rd_data_state[w] = state_t'(rd_state_raw[w]);
    end

    l2_evict_mem #(.EVICT_BANKS(EVICT_BANKS)) u_evict_mem (
        .clk          (clk),
        .wr_rst       (wr_rst),
        .rd_en        (rd_en),
        .wr           (wr_bus),
        .rd_evict_way (rd_data_evict_way)
    );

endmodule

//--- l2_localmem_checker.sv
//****************************************
// L2 local memory checker
//****************************************
`timescale 1ns/1ps

module l2_localmem_checker (
    input  logic                clk,
    input  logic                wr_rst,
    input  logic                rd_en,
    input  logic                wr_en_line,
    input  logic                wr_en_state,
    input  logic                wr_en_evict_way,
    input  logic                wr_en_put_reqs,
    input  logic                wr_all_ways,
    input  l2_mem_pkg::l2_set_t set_in,
    input  l2_mem_pkg::l2_way_t way,
    input  l2_mem_pkg::line_t   wr_data_line,
    input  l2_mem_pkg::l2_tag_t wr_data_tag,
    input  l2_mem_pkg::hprot_t  wr_data_hprot,
    input  l2_mem_pkg::state_t  wr_data_state,
    input  l2_mem_pkg::l2_way_t wr_data_evict_way,
    input  l2_mem_pkg::line_t   rd_data_line  [l2_mem_pkg::L2_WAYS],
    input  l2_mem_pkg::l2_tag_t rd_data_tag   [l2_mem_pkg::L2_WAYS],
    input  l2_mem_pkg::hprot_t  rd_data_hprot [l2_mem_pkg::L2_WAYS],
    input  l2_mem_pkg::state_t  rd_data_state [l2_mem_pkg::L2_WAYS],
    input  l2_mem_pkg::l2_way_t rd_data_evict_way,
    output int                  error_count,
    output int                  check_count
);
    import l2_mem_pkg::*;

    localparam int SETS = 2 ** L2_SET_BITS;

    // field index 0 line, 1 tag, 2 hprot, 3 state
    logic [L2_LINE_BITS-1:0] shadow [SETS][L2_WAYS][4];
    logic                    known [SETS][L2_WAYS][4] = '{default: 1'b0};
    l2_way_t                 shadow_evict [SETS];
    logic                    known_evict [SETS] = '{default: 1'b0};
    logic [L2_LINE_BITS-1:0] exp_val [L2_WAYS][4];
    logic                    exp_ok [L2_WAYS][4];
    l2_way_t                 exp_evict;
    logic                    exp_evict_ok;
    logic [L2_LINE_BITS-1:0] wr_val [4];
    logic [L2_LINE_BITS-1:0] got [L2_WAYS][4];
    logic [3:0]              field_we;
    int                      reads   = 0;
    int                      checked = 0;
    int                      errors  = 0;
    int                      checks  = 0;

    assign error_count = errors;
    assign check_count = checks;

    assign wr_val[0] = wr_data_line;
    assign wr_val[1] = L2_LINE_BITS'(wr_data_tag);
    assign wr_val[2] = L2_LINE_BITS'(wr_data_hprot);
    assign wr_val[3] = L2_LINE_BITS'(wr_data_state);

    // which field a write touches
    assign field_we[0] = wr_en_line | wr_en_put_reqs;
    assign field_we[1] = wr_en_put_reqs;
    assign field_we[2] = wr_en_put_reqs;
    assign field_we[3] = wr_en_state | wr_en_put_reqs | wr_all_ways;

    always_comb begin
        for (int w = 0; w < L2_WAYS; w++) begin
            got[w][0] = rd_data_line[w];
            got[w][1] = L2_LINE_BITS'(rd_data_tag[w]);
            got[w][2] = L2_LINE_BITS'(rd_data_hprot[w]);
            got[w][3] = L2_LINE_BITS'(rd_data_state[w]);
        end
    end

    function automatic string field_name(input int f);
        case (f)
            0: return "rd_data_line";
            1: return "rd_data_tag";
            2: return "rd_data_hprot";
            default: return "rd_data_state";
        endcase
    endfunction

    task automatic compare(input string name, input logic [L2_LINE_BITS-1:0] value,
                           input logic [L2_LINE_BITS-1:0] expected);
        checks++;
        if (value !== expected) begin
            errors++;
            $display("** Error: %s = 0x%0h, expected 0x%0h at %0t", name, value, expected,
                     $time);
        end
    endtask

    // expected read data is taken before this edge's write (read-first)
    always @(posedge clk) begin
        if (wr_rst || rd_en) begin
            for (int w = 0; w < L2_WAYS; w++) begin
                for (int f = 0; f < 4; f++) begin
                    exp_val[w][f] = wr_rst ? '0 : shadow[set_in][w][f];
                    exp_ok[w][f]  = wr_rst || known[set_in][w][f];
                end
            end
            exp_evict    = wr_rst ? '0 : shadow_evict[set_in];
            exp_evict_ok = wr_rst || known_evict[set_in];
            reads++;
        end
        for (int w = 0; w < L2_WAYS; w++) begin
            for (int f = 0; f < 4; f++) begin
                if (field_we[f] && (wr_all_ways || w == int'(way))) begin
                    shadow[set_in][w][f] = wr_val[f];
                    known[set_in][w][f]  = 1'b1;
                end
            end
        end
        if (wr_en_evict_way) begin
            shadow_evict[set_in] = wr_data_evict_way;
            known_evict[set_in]  = 1'b1;
        end
    end

    always @(negedge clk) begin
        if (reads != checked) begin
            checked = reads;
            for (int w = 0; w < L2_WAYS; w++) begin
                for (int f = 0; f < 4; f++) begin
                    if (exp_ok[w][f]) begin
                        compare($sformatf("%s[%0d]", field_name(f), w), got[w][f],
                                exp_val[w][f]);
                    end
                end
            end
            if (exp_evict_ok) begin
                compare("rd_data_evict_way", L2_LINE_BITS'(rd_data_evict_way),
                        L2_LINE_BITS'(exp_evict));
            end
        end
    end

endmodule

//--- tb_l2_localmem.sv
//****************************************
// L2 local memory testbench
//****************************************
`timescale 1ns/1ps

module tb_l2_localmem;
    import l2_mem_pkg::*;

    localparam int          CLK_PERIOD     = 20;
    localparam int          TIMEOUT_FACTOR = 4;
    localparam int          TIMEOUT_MARGIN = 30;
    localparam logic [31:0] LFSR_SEED      = 32'h299483d3;

    typedef enum logic [2:0] {
        OP_IDLE, OP_READ, OP_PUT, OP_LINE, OP_STATE, OP_ALL, OP_EVICT, OP_READ_PUT
    } op_kind_t;

    // a fixed value replaces the first field of the op
    // blank data comes from the LFSR
    typedef struct packed {
        op_kind_t    kind;
        l2_set_t     set;
        l2_way_t     way;
        logic        fixed;
        logic [63:0] val;
    } op_t;

    logic        clk = 1'b0;
    logic        wr_rst;
    logic        rd_en;
    logic        wr_en_line;
    logic        wr_en_state;
    logic        wr_en_evict_way;
    logic        wr_en_put_reqs;
    logic        wr_all_ways;
    l2_set_t     set_in;
    l2_way_t     way;
    line_t       wr_data_line;
    l2_tag_t     wr_data_tag;
    hprot_t      wr_data_hprot;
    state_t      wr_data_state;
    l2_way_t     wr_data_evict_way;
    line_t       rd_data_line [L2_WAYS];
    l2_tag_t     rd_data_tag [L2_WAYS];
    hprot_t      rd_data_hprot [L2_WAYS];
    state_t      rd_data_state [L2_WAYS];
    l2_way_t     rd_data_evict_way;
    int          error_count;
    int          check_count;
    op_t         ops [$];
    logic [31:0] lfsr = LFSR_SEED;
    logic        table_ready = 1'b0;

    l2_localmem UUT (.*);

    l2_localmem_checker u_checker (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {1'b0, s[31:1]} ^ (s[0] ? 32'h80200003 : 32'h0);
    endfunction

    task automatic take_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v[i] = lfsr[0];
        end
    endtask

    task automatic field_value(input op_t op, input int n, output logic [63:0] v);
        if (op.fixed) begin
            v = op.val;
        end else begin
            take_bits(n, v);
        end
    endtask

    task automatic add_op(input op_kind_t kind, input int set, input int way,
                          input logic fixed = 1'b0, input logic [63:0] val = '0);
        ops.push_back('{kind, l2_set_t'(set), l2_way_t'(way), fixed, val});
    endtask

    task automatic apply_op(input op_t op);
        logic [63:0] v;
        rd_en           = op.kind inside {OP_READ, OP_READ_PUT};
        wr_en_put_reqs  = op.kind inside {OP_PUT, OP_READ_PUT};
        wr_en_line      = (op.kind == OP_LINE);
        wr_en_state     = (op.kind == OP_STATE);
        wr_all_ways     = (op.kind == OP_ALL);
        wr_en_evict_way = (op.kind == OP_EVICT);
        set_in          = op.set;
        way             = op.way;
        case (op.kind)
            OP_PUT, OP_READ_PUT: begin
                field_value(op, L2_LINE_BITS, v);
                wr_data_line = v;
                take_bits(L2_TAG_BITS, v);
                wr_data_tag = l2_tag_t'(v);
                take_bits(1, v);
                wr_data_hprot = hprot_t'(v);
                take_bits(3, v);
                wr_data_state = state_t'(v[2:0]);
            end
            OP_LINE: begin
                field_value(op, L2_LINE_BITS, v);
                wr_data_line = v;
            end
            OP_STATE, OP_ALL: begin
                field_value(op, 3, v);
                wr_data_state = state_t'(v[2:0]);
            end
            OP_EVICT: begin
                field_value(op, L2_WAY_BITS, v);
                wr_data_evict_way = l2_way_t'(v);
            end
            default: begin
            end
        endcase
    endtask

    task automatic build_table();
        // sets 5 and 40 sit in different banks, 63 is the last row
        add_op(OP_PUT, 5, 0);
        add_op(OP_PUT, 5, 2);
        add_op(OP_PUT, 40, 1);
        add_op(OP_PUT, 40, 3, 1'b1, 64'h0123_4567_89ab_cdef);
        add_op(OP_PUT, 63, 0);
        add_op(OP_READ, 5, 0);
        add_op(OP_READ, 40, 0);
        add_op(OP_PUT, 5, 1);
        add_op(OP_READ, 5, 3);
        add_op(OP_READ, 63, 2);
        add_op(OP_LINE, 5, 2);
        add_op(OP_LINE, 40, 3);
        add_op(OP_STATE, 40, 1, 1'b1, 64'(SHARED));
        add_op(OP_READ, 5, 0);
        add_op(OP_READ, 40, 0);
        add_op(OP_ALL, 5, 0, 1'b1, 64'(MODIFIED));
        add_op(OP_READ, 5, 0);
        // eviction pointer ignores the way input
        add_op(OP_EVICT, 5, 0, 1'b1, 64'd3);
        add_op(OP_EVICT, 40, 2);
        add_op(OP_READ, 5, 1);
        add_op(OP_READ, 40, 2);
        add_op(OP_READ_PUT, 40, 3);
        add_op(OP_READ, 40, 0);
    endtask

    initial begin
        wr_rst            = 1'b1;
        apply_op('0);
        wr_data_line      = '0;
        wr_data_tag       = '0;
        wr_data_hprot     = '0;
        wr_data_state     = INVALID;
        wr_data_evict_way = '0;
        build_table();
        table_ready = 1'b1;
        repeat (4) @(posedge clk);
        #2;
        wr_rst = 1'b0;
        foreach (ops[i]) begin
            @(posedge clk);
            #2;
            apply_op(ops[i]);
        end
        @(posedge clk);
        #2;
        apply_op('0);
        repeat (2) @(posedge clk);
        @(negedge clk);
        $display("read checks: %0d, errors: %0d", check_count, error_count);
        if (check_count == 0) begin
            $display("no read data was compared");
        end
        if (error_count == 0 && check_count > 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        wait (table_ready);
        #(CLK_PERIOD * (ops.size() * TIMEOUT_FACTOR + TIMEOUT_MARGIN));
        $display("timeout: the stimulus table did not finish in time");
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- l2_localmem.f
l2_mem_pkg.sv
l2_wr_if.sv
l2_way_decoder.sv
l2_bank_array.sv
l2_evict_mem.sv
l2_localmem.sv
l2_localmem_checker.sv
tb_l2_localmem.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the L2 local memory testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_l2_localmem -f l2_localmem.f -o sim_l2_localmem
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/sim_l2_localmem)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "RESULT: PASS"; then
    exit 0
fi
echo "pass message not found"
exit 1
